//--- Bender.yml
package:
  name: async_fifo

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fifo_pkg.sv
      - source/ram_if.sv
      - source/dp_ram.sv
      - source/wr_ptr_full.sv
      - source/rd_ptr_empty.sv
      - source/ptr_sync.sv
      - source/async_fifo.sv

  - target: test
    include_dirs:
      - source
    files:
      - testbench/async_fifo_sva.sv
      - testbench/tb_async_fifo.sv

//--- flist.f
+incdir+source
source/fifo_pkg.sv
source/ram_if.sv
source/dp_ram.sv
source/wr_ptr_full.sv
source/rd_ptr_empty.sv
source/ptr_sync.sv
source/async_fifo.sv
testbench/async_fifo_sva.sv
testbench/tb_async_fifo.sv

//--- source/async_fifo.sv
`timescale 1ns/100ps
`include "fifo_params.svh"

module async_fifo (
    // write domain
    input  logic                   wclk,
    input  logic                   wrstn,
    input  logic                   winc,
    input  logic [`FIFO_WIDTH-1:0] wdata,
    output logic                   wfull,

    // read domain
    input  logic                   rclk,
    input  logic                   rrstn,
    input  logic                   rinc,
    output logic [`FIFO_WIDTH-1:0] rdata,
    output logic                   rempty
);
    import fifo_pkg::*;

    ptr_t wgray;        // write pointer, wclk domain
    ptr_t rgray;        // read pointer, rclk domain
    ptr_t wgray_sync;   // write pointer seen from rclk
    ptr_t rgray_sync;   // read pointer seen from wclk

    ram_if i_ram_if ();

    dp_ram i_dp_ram (
        .wclk (wclk),
        .rclk (rclk),
        .mem  (i_ram_if.mem)
    );

    wr_ptr_full i_wr_ptr_full (
        .wclk       (wclk),
        .wrstn      (wrstn),
        .winc       (winc),
        .wdata      (wdata),
        .rgray_sync (rgray_sync),
        .wgray      (wgray),
        .wfull      (wfull),
        .wr         (i_ram_if.wr)
    );

    rd_ptr_empty i_rd_ptr_empty (
        .rclk       (rclk),
        .rrstn      (rrstn),
        .rinc       (rinc),
        .wgray_sync (wgray_sync),
        .rgray      (rgray),
        .rempty     (rempty),
        .rd         (i_ram_if.rd)
    );

    // write pointer into the read domain
    ptr_sync i_sync_w2r (
        .clk      (rclk),
        .rstn     (rrstn),
        .gray_in  (wgray),
        .gray_out (wgray_sync)
    );

    // read pointer into the write domain
    ptr_sync i_sync_r2w (
        .clk      (wclk),
        .rstn     (wrstn),
        .gray_in  (rgray),
        .gray_out (rgray_sync)
    );

    assign rdata = i_ram_if.rdata;

endmodule

//--- source/dp_ram.sv
`timescale 1ns/100ps
`include "fifo_params.svh"

module dp_ram (
    input logic wclk,
    input logic rclk,
    ram_if.mem  mem
);
    import fifo_pkg::*;

    data_t mem_array [`FIFO_DEPTH];   // storage, no reset

    // write side, one word per accepted write
    always_ff @(posedge wclk) begin
        if (mem.wen) begin
            mem_array[mem.waddr] <= mem.wdata;
        end
    end

    // read side is registered, so the word shows up one rclk after ren
    // and stays there until the next accepted read
    always_ff @(posedge rclk) begin
        if (mem.ren) begin
            mem.rdata <= mem_array[mem.raddr];
        end
    end

endmodule

//--- source/fifo_params.svh
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// storage size of the FIFO in words
`define FIFO_DEPTH 16

// bits per data word
`define FIFO_WIDTH 8

// address width, log2 of FIFO_DEPTH
`define FIFO_AW 4

// pointers carry one extra bit to tell a full FIFO from an empty one
// after the address has wrapped, so they are FIFO_AW+1 bits wide
// (FIFO_DEPTH must stay a power of two for the Gray wrap to work)

`endif

//--- source/fifo_pkg.sv
`include "fifo_params.svh"

package fifo_pkg;

    // one stored word
    typedef logic [`FIFO_WIDTH-1:0] data_t;

    // memory address, selects one of FIFO_DEPTH entries
    typedef logic [`FIFO_AW-1:0] addr_t;

    // binary or Gray pointer, one wrap bit above the address
    typedef logic [`FIFO_AW:0] ptr_t;

endpackage

//--- source/ptr_sync.sv
`timescale 1ns/100ps

module ptr_sync (
    input  logic          clk,    // destination clock
    input  logic          rstn,   // destination reset
    input  fifo_pkg::ptr_t gray_in,
    output fifo_pkg::ptr_t gray_out
);
    import fifo_pkg::*;

    ptr_t sync_q1;   // first stage, may go metastable

    // gray_in moves one bit per step, so a sample taken mid-change
    // still lands on either the old or the new pointer
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_q1  <= '0;
            gray_out <= '0;
        end else begin
            sync_q1  <= gray_in;
            gray_out <= sync_q1;
        end
    end

endmodule

//--- source/ram_if.sv
`timescale 1ns/100ps

interface ram_if;
    import fifo_pkg::*;

    // write port, wclk domain
    logic  wen;
    addr_t waddr;
    data_t wdata;

    // read port, rclk domain
    logic  ren;
    addr_t raddr;
    data_t rdata;

    modport wr (
        output wen,
        output waddr,
        output wdata
    );

    modport rd (
        output ren,
        output raddr,
        input  rdata
    );

    modport mem (
        input  wen,
        input  waddr,
        input  wdata,
        input  ren,
        input  raddr,
        output rdata
    );

endinterface

//--- source/rd_ptr_empty.sv
`timescale 1ns/100ps
`include "fifo_params.svh"

module rd_ptr_empty (
    input  logic          rclk,
    input  logic          rrstn,
    input  logic          rinc,
    input  fifo_pkg::ptr_t wgray_sync,   // write pointer, already in rclk domain
    output fifo_pkg::ptr_t rgray,
    output logic          rempty,
    ram_if.rd             rd
);
    import fifo_pkg::*;

    ptr_t rbin;         // binary read pointer
    ptr_t rbin_next;
    ptr_t rgray_next;
    logic rpop;         // accepted read

    // reads against an empty FIFO are ignored and leave rdata alone
    assign rpop = rinc & ~rempty;

    assign rbin_next  = rbin + ptr_t'(rpop);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rbin  <= '0;
            rgray <= '0;
        end else begin
            rbin  <= rbin_next;
            rgray <= rgray_next;
        end
    end

    // equal pointers, wrap bit included, means nothing left to read.
    // the synchronized write pointer lags, so this flag is pessimistic
    // and only clears a couple of rclk edges after the write
    assign rempty = (rgray == wgray_sync);

    // read strobe and address for the memory; the word at raddr is
    // loaded into rdata at the same edge that advances rbin
    assign rd.ren   = rpop;
    assign rd.raddr = rbin[`FIFO_AW-1:0];

endmodule

//--- source/wr_ptr_full.sv
`timescale 1ns/100ps
`include "fifo_params.svh"

module wr_ptr_full (
    input  logic           wclk,
    input  logic           wrstn,
    input  logic           winc,
    input  fifo_pkg::data_t wdata,
    input  fifo_pkg::ptr_t  rgray_sync,   // read pointer, already in wclk domain
    output fifo_pkg::ptr_t  wgray,
    output logic           wfull,
    ram_if.wr              wr
);
    import fifo_pkg::*;

    ptr_t wbin;         // binary write pointer
    ptr_t wbin_next;
    ptr_t wgray_next;
    ptr_t rgray_full;   // read pointer as it looks when the FIFO is full
    logic wpush;        // accepted write

    // a write against a full FIFO is simply dropped
    assign wpush = winc & ~wfull;

    // next binary value and its Gray form come out of the same increment,
    // so both registers always hold the same position
    assign wbin_next  = wbin + ptr_t'(wpush);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wbin  <= '0;
            wgray <= '0;
        end else begin
            wbin  <= wbin_next;
            wgray <= wgray_next;
        end
    end

    // full means the writer is exactly one lap ahead of the reader;
    // in Gray code that is the read pointer with its top two bits flipped
    assign rgray_full = {~rgray_sync[`FIFO_AW:`FIFO_AW-1], rgray_sync[`FIFO_AW-2:0]};

    // built from the registered wgray, so it rises in the cycle after the
    // filling write and falls only once the reader's pointer crosses over
    assign wfull = (wgray == rgray_full);

    // memory write port
    assign wr.wen   = wpush;
    assign wr.waddr = wbin[`FIFO_AW-1:0];   // wrap bit dropped
    assign wr.wdata = wdata;

endmodule

//--- testbench/async_fifo_sva.sv
`timescale 1ns/100ps

module async_fifo_sva (
    input logic           wclk,
    input logic           wrstn,
    input logic           wfull,
    input logic           rclk,
    input logic           rrstn,
    input logic           rempty,
    input fifo_pkg::ptr_t wgray,
    input fifo_pkg::ptr_t rgray
);
    import fifo_pkg::*;

    int assert_failures = 0;   // read by the testbench at the end of the run

    // a write against a full FIFO must leave the write pointer where it is
    a_no_write_when_full: assert property (@(posedge wclk) disable iff (!wrstn)
        wfull |=> $stable(wgray))
        else begin
            $error("write accepted while wfull is set");
            assert_failures++;
        end

    a_no_read_when_empty: assert property (@(posedge rclk) disable iff (!rrstn)
        rempty |=> $stable(rgray))
        else begin
            $error("read accepted while rempty is set");
            assert_failures++;
        end

    // Gray pointers may only move one bit per cycle
    a_wgray_one_bit: assert property (@(posedge wclk) disable iff (!wrstn)
        $countones(wgray ^ $past(wgray)) <= 1)
        else begin
            $error("wgray changed by more than one bit");
            assert_failures++;
        end

    a_rgray_one_bit: assert property (@(posedge rclk) disable iff (!rrstn)
        $countones(rgray ^ $past(rgray)) <= 1)
        else begin
            $error("rgray changed by more than one bit");
            assert_failures++;
        end

    a_reset_empty: assert property (@(posedge rclk)
        !rrstn |-> rempty)
        else begin
            $error("rempty low during read reset");
            assert_failures++;
        end

    a_reset_not_full: assert property (@(posedge wclk)
        !wrstn |-> !wfull)
        else begin
            $error("wfull high during write reset");
            assert_failures++;
        end

endmodule

bind async_fifo async_fifo_sva i_sva (
    .wclk   (wclk),
    .wrstn  (wrstn),
    .wfull  (wfull),
    .rclk   (rclk),
    .rrstn  (rrstn),
    .rempty (rempty),
    .wgray  (wgray),
    .rgray  (rgray)
);

//--- testbench/tb_async_fifo.sv
`timescale 1ns/100ps
`include "fifo_params.svh"

module tb_async_fifo;
    import fifo_pkg::*;

    localparam int rand_cycles   = 400;
    // rough length of each test in rclk cycles
    localparam int budget_cycles = 4 + 40 + 6 + 24 + 60 + rand_cycles + 40;
    localparam int timeout_ns    = (budget_cycles + 100) * 100;

    logic  wclk;
    logic  wrstn;
    logic  winc;
    data_t wdata;
    logic  wfull;
    logic  rclk;
    logic  rrstn;
    logic  rinc;
    data_t rdata;
    logic  rempty;

    data_t       sb [$];              // words written but not yet read
    data_t       cmp_word;
    logic        cmp_pending = 1'b0;
    int          read_count = 0;
    int          errors = 0;
    int          test_errors_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [15:0] lfsr_state = 16'd3665;
    logic        w_en_seq [rand_cycles];
    data_t       w_data_seq [rand_cycles];
    logic        r_en_seq [rand_cycles];

    async_fifo i_dut (.*);

    initial begin
        rclk = 1'b0;
        forever #50 rclk = ~rclk;
    end

    initial begin
        wclk = 1'b0;
        forever #35 wclk = ~wclk;   // unrelated to rclk
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[6:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // oldest accepted write comes back first
    function automatic data_t expected_word();
        if (sb.size() == 0) begin
            $display("error at %0t: read returned a word that was never written", $time);
            errors++;
            return '0;
        end
        return sb.pop_front();
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_errors_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_errors_start);
        end
    endtask

    // returns 10 ns after the edge that accepted the last word
    task automatic write_words(input int n);
        int accepted;
        accepted = 0;
        @(posedge wclk);
        #10;
        wdata = random_bits(8);
        while (accepted < n) begin
            winc = 1'b1;
            @(posedge wclk);
            if (!wfull) begin
                accepted++;
            end
            #10;
            if (!wfull || accepted < n) wdata = random_bits(8);
        end
        winc = 1'b0;
    endtask

    task automatic read_words(input int n);
        int accepted;
        accepted = 0;
        @(posedge rclk);
        #10;
        while (accepted < n) begin
            rinc = 1'b1;
            @(posedge rclk);
            if (!rempty) begin
                accepted++;
            end
            #10;
        end
        rinc = 1'b0;
    endtask

    always @(posedge wclk) begin
        if (wrstn && winc && !wfull) sb.push_back(wdata);
    end

    // rdata is valid one rclk after the read that was accepted
    always @(posedge rclk) begin
        if (cmp_pending) begin
            check_value("rdata", cmp_word, rdata);
            cmp_pending = 1'b0;
        end
        if (rrstn && rinc && !rempty) begin
            cmp_word    = expected_word();
            cmp_pending = 1'b1;
            read_count++;
        end
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the tests did not finish within %0d ns", timeout_ns);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        data_t held;
        int    n;
        int    reads_before;
        int    idle;
        winc  = 1'b0;
        rinc  = 1'b0;
        wdata = '0;
        wrstn = 1'b0;
        rrstn = 1'b0;
        fork
            begin
                repeat (2) @(posedge wclk);
                #10;
                wrstn = 1'b1;
            end
            begin
                repeat (2) @(posedge rclk);
                #10;
                rrstn = 1'b1;
            end
        join

        begin_test();
        @(posedge rclk);
        #10;
        check_value("rempty", 1, rempty);
        check_value("wfull", 0, wfull);
        end_test("reset state");

        begin_test();
        write_words(`FIFO_DEPTH - 1);
        check_value("wfull", 0, wfull);
        write_words(1);
        check_value("wfull", 1, wfull);
        end_test("fill");

        begin_test();
        @(posedge wclk);
        #10;
        winc = 1'b1;
        for (int i = 0; i < 4; i++) begin
            wdata = random_bits(8);
            @(posedge wclk);
            #10;
            check_value("wfull", 1, wfull);
        end
        winc = 1'b0;
        check_value("sb_size", `FIFO_DEPTH, sb.size());
        end_test("overflow drop");

        begin_test();
        read_words(`FIFO_DEPTH);
        check_value("rempty", 1, rempty);
        @(posedge rclk);
        #10;
        held         = rdata;
        reads_before = read_count;
        rinc         = 1'b1;        // reads against an empty FIFO
        repeat (3) @(posedge rclk);
        #10;
        rinc = 1'b0;
        check_value("rdata", held, rdata);
        check_value("read_count", reads_before, read_count);
        end_test("drain and underflow");

        begin_test();
        write_words(1);
        n = 0;
        while (rempty && n < 4) begin
            @(posedge rclk);
            n++;
            #1;
        end
        check_value("rempty_edges_le3", 1, n <= 3);
        read_words(1);
        write_words(`FIFO_DEPTH);
        check_value("wfull", 1, wfull);
        read_words(1);
        n = 0;
        while (wfull && n < 4) begin
            @(posedge wclk);
            n++;
            #1;
        end
        check_value("wfull_edges_le3", 1, n <= 3);
        read_words(`FIFO_DEPTH - 1);
        @(posedge rclk);
        #10;
        check_value("rempty", 1, rempty);
        end_test("latency bound");

        begin_test();
        for (int i = 0; i < rand_cycles; i++) begin
            w_en_seq[i]   = 1'(random_bits(1));
            w_data_seq[i] = random_bits(8);
            r_en_seq[i]   = 1'(random_bits(1));
        end
        fork
            begin
                for (int i = 0; i < rand_cycles; i++) begin
                    @(posedge wclk);
                    #10;
                    winc  = w_en_seq[i];
                    wdata = w_data_seq[i];
                end
                @(posedge wclk);
                #10;
                winc = 1'b0;
            end
            begin
                for (int i = 0; i < rand_cycles; i++) begin
                    @(posedge rclk);
                    #10;
                    rinc = r_en_seq[i];
                end
            end
        join
        rinc = 1'b1;                // drain until empty for a few cycles
        idle = 0;
        while (idle < 6) begin
            @(posedge rclk);
            idle = rempty ? idle + 1 : 0;
            #10;
        end
        rinc = 1'b0;
        check_value("sb_size", 0, sb.size());
        check_value("rempty", 1, rempty);
        end_test("random traffic");

        if (i_dut.i_sva.assert_failures != 0) begin
            $display("%0d assertion failures reported by the bound checker",
                     i_dut.i_sva.assert_failures);
            errors += i_dut.i_sva.assert_failures;
        end
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
